// ==== sim.f ====
ram_pkg.sv
client_port.sv
ram_sequencer.sv
sram_lanes.sv
ram_subsystem.sv
sram_pair_model.sv
tb_ram_subsystem.sv

// ==== ram_golden.txt ====
// client write addr wdata expect group; client 0 mcr, 1 sdram, 2 vram; addr and data in hex
// lines with the same group launch in one cycle; expect is compared on reads only
1 1 0123 89abcdef 0 1
1 0 0123 0 89abcdef 2
2 1 0456 13572468 0 3
2 0 0456 0 13572468 4
0 1 0a5 f123456789abc 0 5
0 0 0a5 0 f123456789abc 6
1 1 ffff a5a55a5a 0 7
2 1 7fff 5a5aa5a5 0 8
1 0 ffff 0 a5a55a5a 9
2 0 7fff 0 5a5aa5a5 10
0 1 321 1111122223333 0 11
1 1 0321 44445555 0 12
2 1 0321 66667777 0 13
0 0 321 0 1111122223333 14
1 0 0321 0 44445555 15
2 0 0321 0 66667777 16
0 1 7ff 8000000000001 0 17
1 1 1234 cafef00d 0 17
2 1 1234 0badf00d 0 17
0 0 7ff 0 8000000000001 18
1 0 1234 0 cafef00d 18
2 0 1234 0 0badf00d 18

// ==== tb_ram_subsystem.sv ====
// tb_ram_subsystem: clock, reset, golden-file stimulus, sram model and result checks.
`timescale 1ns/100ps

module tb_ram_subsystem;

   localparam int max_ops     = 64;
   localparam int ack_timeout = 50;

   logic                clk;
   logic                reset;
   logic                mcr_req_valid;
   ram_pkg::mcr_req_t   mcr_req;
   logic                mcr_busy;
   logic                mcr_ack;
   ram_pkg::mcr_word_t  mcr_rdata;
   logic                sdram_req_valid;
   ram_pkg::sdram_req_t sdram_req;
   logic                sdram_busy;
   logic                sdram_ack;
   ram_pkg::word_t      sdram_rdata;
   logic                vram_req_valid;
   ram_pkg::vram_req_t  vram_req;
   logic                vram_busy;
   logic                vram_ack;
   ram_pkg::word_t      vram_rdata;
   ram_pkg::sram_ctl_t  sram_ctl;
   wire ram_pkg::lane_t sram1_io;
   wire ram_pkg::lane_t sram2_io;

   int          op_count;
   int          op_client [max_ops];  // 0 mcr, 1 sdram, 2 vram.
   logic        op_write  [max_ops];
   logic [15:0] op_addr   [max_ops];
   logic [51:0] op_wdata  [max_ops];
   logic [51:0] op_exp    [max_ops];
   int          op_group  [max_ops];
   int          mcr_hi_writes;

   ram_subsystem ram_subsystem_i (
      .clk             (clk),
      .reset           (reset),
      .mcr_req_valid   (mcr_req_valid),
      .mcr_req         (mcr_req),
      .mcr_busy        (mcr_busy),
      .mcr_ack         (mcr_ack),
      .mcr_rdata       (mcr_rdata),
      .sdram_req_valid (sdram_req_valid),
      .sdram_req       (sdram_req),
      .sdram_busy      (sdram_busy),
      .sdram_ack       (sdram_ack),
      .sdram_rdata     (sdram_rdata),
      .vram_req_valid  (vram_req_valid),
      .vram_req        (vram_req),
      .vram_busy       (vram_busy),
      .vram_ack        (vram_ack),
      .vram_rdata      (vram_rdata),
      .sram_ctl        (sram_ctl),
      .sram1_io        (sram1_io),
      .sram2_io        (sram2_io)
   );

   sram_pair_model sram_pair_model_i (
      .sram_ctl (sram_ctl),
      .sram1_io (sram1_io),
      .sram2_io (sram2_io)
   );

   always #2 clk = ~clk;

   task automatic report_mismatch(input string msg);
      $display("** Error at %0t ns: %s", $time, msg);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_word(input string what, input ram_pkg::word_t actual,
                             input ram_pkg::word_t expected);
      if (actual !== expected)
         report_mismatch($sformatf("%s: got %h, expected %h", what, actual, expected));
   endtask

   task automatic check_mcr(input string what, input ram_pkg::mcr_word_t actual,
                            input ram_pkg::mcr_word_t expected);
      if (actual !== expected)
         report_mismatch($sformatf("%s: got %h, expected %h", what, actual, expected));
   endtask

   task automatic check_ctl(input string what, input ram_pkg::sram_ctl_t actual,
                            input ram_pkg::sram_ctl_t expected);
      if (actual !== expected)
         report_mismatch($sformatf("%s: got %h, expected %h", what, actual, expected));
   endtask

   task automatic check_lane(input string what, input ram_pkg::lane_t actual,
                             input ram_pkg::lane_t expected);
      if (actual !== expected)
         report_mismatch($sformatf("%s: got %h, expected %h", what, actual, expected));
   endtask

   task automatic check_flag(input string what, input logic actual, input logic expected);
      if (actual !== expected)
         report_mismatch($sformatf("%s: got %b, expected %b", what, actual, expected));
   endtask

   task automatic check_count(input string what, input int actual, input int expected);
      if (actual != expected)
         report_mismatch($sformatf("%s: got %0d, expected %0d", what, actual, expected));
   endtask

   function automatic string client_name(input int c);
      case (c)
         0:       return "mcr";
         1:       return "sdram";
         default: return "vram";
      endcase
   endfunction

   function automatic logic ack_of(input int c);
      case (c)
         0:       return mcr_ack;
         1:       return sdram_ack;
         default: return vram_ack;
      endcase
   endfunction

   function automatic logic busy_of(input int c);
      case (c)
         0:       return mcr_busy;
         1:       return sdram_busy;
         default: return vram_busy;
      endcase
   endfunction

   task automatic load_golden();
      int          fd;
      int          client;
      int          wr;
      int          group;
      logic [15:0] addr;
      logic [51:0] wdata;
      logic [51:0] exp_data;
      string       line;

      fd = $fopen("ram_golden.txt", "r");
      if (fd == 0)
         abort_run("could not open ram_golden.txt for reading");
      op_count = 0;
      while (!$feof(fd)) begin
         line = "";
         if ($fgets(line, fd) > 0 && line.len() > 2 && line.substr(0, 1) != "//") begin
            if ($sscanf(line, "%d %d %h %h %h %d", client, wr, addr, wdata, exp_data,
                        group) != 6)
               abort_run({"golden file line could not be parsed: ", line});
            if (op_count >= max_ops)
               abort_run("golden file holds more operations than the testbench allows");
            op_client[op_count] = client;
            op_write[op_count]  = (wr != 0);
            op_addr[op_count]   = addr;
            op_wdata[op_count]  = wdata;
            op_exp[op_count]    = exp_data;
            op_group[op_count]  = group;
            op_count++;
         end
      end
      $fclose(fd);
   endtask

   task automatic check_idle();
      ram_pkg::sram_ctl_t idle_ctl;

      idle_ctl.addr = '0;
      idle_ctl.oe_n = 1'b1;
      idle_ctl.we_n = 1'b1;
      idle_ctl.ce_n = 1'b1;
      idle_ctl.ub_n = 1'b1;
      idle_ctl.lb_n = 1'b1;
      check_ctl("sram control at idle", sram_ctl, idle_ctl);
      check_flag("mcr busy at idle", mcr_busy, 1'b0);
      check_flag("sdram busy at idle", sdram_busy, 1'b0);
      check_flag("vram busy at idle", vram_busy, 1'b0);
      check_flag("mcr ack at idle", mcr_ack, 1'b0);
      check_flag("sdram ack at idle", sdram_ack, 1'b0);
      check_flag("vram ack at idle", vram_ack, 1'b0);
      check_mcr("mcr rdata at idle", mcr_rdata, '0);
      check_word("sdram rdata at idle", sdram_rdata, '0);
      check_word("vram rdata at idle", vram_rdata, '0);
   endtask

   task automatic drive_request(input int i);
      case (op_client[i])
         0: begin
            mcr_req.write = op_write[i];
            mcr_req.addr  = op_addr[i][11:0];
            mcr_req.wdata = op_wdata[i];
            mcr_req_valid = 1'b1;
         end
         1: begin
            sdram_req.write = op_write[i];
            sdram_req.addr  = op_addr[i];
            sdram_req.wdata = op_wdata[i][31:0];
            sdram_req_valid = 1'b1;
         end
         default: begin
            vram_req.write = op_write[i];
            vram_req.addr  = op_addr[i][14:0];
            vram_req.wdata = op_wdata[i][31:0];
            vram_req_valid = 1'b1;
         end
      endcase
   endtask

   task automatic check_read(input int i);
      case (op_client[i])
         0:       check_mcr("mcr read data", mcr_rdata, op_exp[i]);
         1:       check_word("sdram read data", sdram_rdata, op_exp[i][31:0]);
         default: check_word("vram read data", vram_rdata, op_exp[i][31:0]);
      endcase
   endtask

   // launch ops first..last-1 together, then collect every ack.
   task automatic run_group(input int first, input int last);
      int   cycles;
      int   waiting;
      int   c;
      int   d;
      int   i;
      int   ack_cycle [3];
      int   op_of [3];
      logic launched [3];
      logic done [3];

      for (c = 0; c < 3; c++) begin
         ack_cycle[c] = 0;
         op_of[c]     = -1;
         launched[c]  = 1'b0;
         done[c]      = 1'b0;
      end
      for (i = first; i < last; i++) begin
         c = op_client[i];
         if (launched[c])
            abort_run($sformatf("golden group %0d uses one client twice", op_group[i]));
         launched[c] = 1'b1;
         op_of[c]    = i;
         drive_request(i);
      end
      waiting = last - first;
      cycles  = 0;
      while (waiting > 0) begin
         @(negedge clk);
         cycles++;
         mcr_req_valid   = 1'b0;
         sdram_req_valid = 1'b0;
         vram_req_valid  = 1'b0;
         for (c = 0; c < 3; c++) begin
            if (launched[c] && !done[c]) begin
               if (ack_of(c)) begin
                  done[c]      = 1'b1;
                  ack_cycle[c] = cycles;
                  waiting--;
                  check_flag({client_name(c), " busy in ack cycle"}, busy_of(c), 1'b0);
                  if (!op_write[op_of[c]])
                     check_read(op_of[c]);
               end else begin
                  check_flag({client_name(c), " busy before ack"}, busy_of(c), 1'b1);
               end
            end
         end
         if (waiting > 0 && cycles >= ack_timeout) begin
            for (c = 0; c < 3; c++) begin
               if (launched[c] && !done[c])
                  abort_run($sformatf("timeout: the %s client never acknowledged in %0d cycles",
                                      client_name(c), ack_timeout));
            end
         end
      end
      c = op_client[first];
      if (last - first == 1)
         check_count({client_name(c), " solo latency"}, ack_cycle[c], (c == 0) ? 4 : 3);
      for (c = 0; c < 2; c++) begin
         for (d = c + 1; d < 3; d++) begin
            if (launched[c] && launched[d])
               check_flag({"ack order ", client_name(c), " before ", client_name(d)},
                          ack_cycle[c] < ack_cycle[d], 1'b1);
         end
      end
      @(negedge clk);  // one quiet cycle between groups.
   endtask

   // first half of an mcr write carries only the top nibble on lane 1.
   always @(negedge clk) begin
      if (reset === 1'b0 && sram_ctl.ce_n === 1'b0 && sram_ctl.oe_n === 1'b1 &&
          sram_ctl.addr[17:13] == 5'b01000 && sram_ctl.addr[0] == 1'b0) begin
         mcr_hi_writes++;
         check_lane("lane 1 upper bits in first mcr write half", sram1_io & 16'hfff0,
                    16'h0000);
      end
   end

   initial begin
      int i;
      int j;

      clk             = 1'b0;
      reset           = 1'b1;
      mcr_req_valid   = 1'b0;
      mcr_req         = '0;
      sdram_req_valid = 1'b0;
      sdram_req       = '0;
      vram_req_valid  = 1'b0;
      vram_req        = '0;
      mcr_hi_writes   = 0;
      load_golden();
      repeat (4) begin
         @(negedge clk);
         check_idle();
      end
      reset = 1'b0;
      @(negedge clk);
      check_idle();
      i = 0;
      while (i < op_count) begin
         j = i;
         while (j < op_count && op_group[j] == op_group[i])
            j++;
         run_group(i, j);
         i = j;
      end
      check_flag("first mcr write halves seen on the pins", mcr_hi_writes > 0, 1'b1);
      $display("Simulation passed");
      $finish;
   end

endmodule

// ==== sram_pair_model.sv ====
// sram_pair_model: two asynchronous 16-bit sram chips on shared address and control pins.
`timescale 1ns/100ps

module sram_pair_model (
   input  ram_pkg::sram_ctl_t  sram_ctl,
   inout  wire ram_pkg::lane_t sram1_io,
   inout  wire ram_pkg::lane_t sram2_io
);

   ram_pkg::lane_t mem1 [0:262143];  // chip 1, upper half.
   ram_pkg::lane_t mem2 [0:262143];  // chip 2, lower half.
   logic           rd_en;
   logic           we_n;

   assign rd_en = ~sram_ctl.ce_n & ~sram_ctl.oe_n;
   assign we_n  = sram_ctl.we_n;

   assign sram1_io = rd_en ? mem1[sram_ctl.addr] : 'z;
   assign sram2_io = rd_en ? mem2[sram_ctl.addr] : 'z;

   // data is taken as we_n rises.
   always @(posedge we_n) begin
      if (sram_ctl.ce_n === 1'b0) begin
         if (sram_ctl.ub_n === 1'b0) begin
            mem1[sram_ctl.addr][15:8] = sram1_io[15:8];
            mem2[sram_ctl.addr][15:8] = sram2_io[15:8];
         end
         if (sram_ctl.lb_n === 1'b0) begin
            mem1[sram_ctl.addr][7:0] = sram1_io[7:0];
            mem2[sram_ctl.addr][7:0] = sram2_io[7:0];
         end
      end
   end

endmodule

// ==== ram_subsystem.sv ====
// ram_subsystem: three client ports, sequencer and lane drivers on a shared sram pair.
`timescale 1ns/100ps

module ram_subsystem (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 mcr_req_valid,
   input  ram_pkg::mcr_req_t    mcr_req,
   output logic                 mcr_busy,
   output logic                 mcr_ack,
   output ram_pkg::mcr_word_t   mcr_rdata,
   input  logic                 sdram_req_valid,
   input  ram_pkg::sdram_req_t  sdram_req,
   output logic                 sdram_busy,
   output logic                 sdram_ack,
   output ram_pkg::word_t       sdram_rdata,
   input  logic                 vram_req_valid,
   input  ram_pkg::vram_req_t   vram_req,
   output logic                 vram_busy,
   output logic                 vram_ack,
   output ram_pkg::word_t       vram_rdata,
   output ram_pkg::sram_ctl_t   sram_ctl,
   inout  wire ram_pkg::lane_t  sram1_io,
   inout  wire ram_pkg::lane_t  sram2_io
);

   logic                mcr_pending;
   logic                sdram_pending;
   logic                vram_pending;
   logic                mcr_grant;
   logic                sdram_grant;
   logic                vram_grant;
   ram_pkg::mcr_req_t   mcr_pending_req;
   ram_pkg::sdram_req_t sdram_pending_req;
   ram_pkg::vram_req_t  vram_pending_req;
   ram_pkg::lane_cmd_t  lane_cmd;

   client_port #(.req_t(ram_pkg::mcr_req_t)) mcr_port (
      .clk         (clk),
      .reset       (reset),
      .req_valid   (mcr_req_valid),
      .req         (mcr_req),
      .grant       (mcr_grant),
      .ack         (mcr_ack),
      .busy        (mcr_busy),
      .pending     (mcr_pending),
      .pending_req (mcr_pending_req)
   );

   client_port #(.req_t(ram_pkg::sdram_req_t)) sdram_port (
      .clk         (clk),
      .reset       (reset),
      .req_valid   (sdram_req_valid),
      .req         (sdram_req),
      .grant       (sdram_grant),
      .ack         (sdram_ack),
      .busy        (sdram_busy),
      .pending     (sdram_pending),
      .pending_req (sdram_pending_req)
   );

   client_port #(.req_t(ram_pkg::vram_req_t)) vram_port (
      .clk         (clk),
      .reset       (reset),
      .req_valid   (vram_req_valid),
      .req         (vram_req),
      .grant       (vram_grant),
      .ack         (vram_ack),
      .busy        (vram_busy),
      .pending     (vram_pending),
      .pending_req (vram_pending_req)
   );

   ram_sequencer ram_sequencer_i (
      .clk           (clk),
      .reset         (reset),
      .mcr_pending   (mcr_pending),
      .mcr_req       (mcr_pending_req),
      .sdram_pending (sdram_pending),
      .sdram_req     (sdram_pending_req),
      .vram_pending  (vram_pending),
      .vram_req      (vram_pending_req),
      .mcr_grant     (mcr_grant),
      .sdram_grant   (sdram_grant),
      .vram_grant    (vram_grant),
      .sram_ctl      (sram_ctl),
      .lane_cmd      (lane_cmd)
   );

   sram_lanes sram_lanes_i (
      .clk         (clk),
      .reset       (reset),
      .lane_cmd    (lane_cmd),
      .sram1_io    (sram1_io),
      .sram2_io    (sram2_io),
      .mcr_rdata   (mcr_rdata),
      .sdram_rdata (sdram_rdata),
      .vram_rdata  (vram_rdata),
      .mcr_ack     (mcr_ack),
      .sdram_ack   (sdram_ack),
      .vram_ack    (vram_ack)
   );

endmodule

// ==== sram_lanes.sv ====
// sram_lanes: lane tristate drivers, read capture, mcr half assembly and ack pulses.
`timescale 1ns/100ps

module sram_lanes (
   input  logic                 clk,
   input  logic                 reset,
   input  ram_pkg::lane_cmd_t   lane_cmd,
   inout  wire ram_pkg::lane_t  sram1_io,
   inout  wire ram_pkg::lane_t  sram2_io,
   output ram_pkg::mcr_word_t   mcr_rdata,
   output ram_pkg::word_t       sdram_rdata,
   output ram_pkg::word_t       vram_rdata,
   output logic                 mcr_ack,
   output logic                 sdram_ack,
   output logic                 vram_ack
);

   logic [19:0] mcr_hold_q;  // bits 51..32 from the first half.
   logic        rd;

   assign sram1_io = lane_cmd.drive ? lane_cmd.lane1 : 'z;
   assign sram2_io = lane_cmd.drive ? lane_cmd.lane2 : 'z;

   assign rd = ~lane_cmd.drive;

   always_ff @(posedge clk) begin
      if (rd && lane_cmd.capture == ram_pkg::mcr_first)
         mcr_hold_q <= {sram1_io[3:0], sram2_io};
   end

   // capture at the edge that closes the sram cycle.
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         mcr_ack     <= 1'b0;
         sdram_ack   <= 1'b0;
         vram_ack    <= 1'b0;
         mcr_rdata   <= '0;
         sdram_rdata <= '0;
         vram_rdata  <= '0;
      end else begin
         mcr_ack   <= (lane_cmd.capture == ram_pkg::mcr_second);
         sdram_ack <= (lane_cmd.capture == ram_pkg::sdram_slot);
         vram_ack  <= (lane_cmd.capture == ram_pkg::vram_slot);
         if (rd) begin
            case (lane_cmd.capture)
               ram_pkg::mcr_second:
                  mcr_rdata <= {mcr_hold_q, sram1_io, sram2_io};
               ram_pkg::sdram_slot:
                  sdram_rdata <= {sram1_io, sram2_io};
               ram_pkg::vram_slot:
                  vram_rdata <= {sram1_io, sram2_io};
               default: ;  // idle or first mcr half.
            endcase
         end
      end
   end

endmodule

// ==== ram_sequencer.sv ====
// ram_sequencer: round-based client arbitration, sram address and control generation.
`timescale 1ns/100ps

module ram_sequencer (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  mcr_pending,
   input  ram_pkg::mcr_req_t     mcr_req,
   input  logic                  sdram_pending,
   input  ram_pkg::sdram_req_t   sdram_req,
   input  logic                  vram_pending,
   input  ram_pkg::vram_req_t    vram_req,
   output logic                  mcr_grant,
   output logic                  sdram_grant,
   output logic                  vram_grant,
   output ram_pkg::sram_ctl_t    sram_ctl,
   output ram_pkg::lane_cmd_t    lane_cmd
);

   ram_pkg::seq_state_t state_q;
   ram_pkg::seq_state_t next_state;
   ram_pkg::mcr_req_t   mcr_q;
   ram_pkg::sram_ctl_t  ctl_q;
   ram_pkg::sram_ctl_t  ctl_d;
   ram_pkg::lane_cmd_t  cmd_d;
   logic                wr_tog_q;
   logic                wr_seen_q;

   // idle, then mcr, then one 32-bit slot with sdram first.
   always_comb begin
      case (state_q)
         ram_pkg::idle: begin
            if (mcr_pending)
               next_state = ram_pkg::mcr_first;
            else if (sdram_pending)
               next_state = ram_pkg::sdram_slot;
            else if (vram_pending)
               next_state = ram_pkg::vram_slot;
            else
               next_state = ram_pkg::idle;
         end
         ram_pkg::mcr_first:
            next_state = ram_pkg::mcr_second;
         ram_pkg::mcr_second: begin
            if (sdram_pending)
               next_state = ram_pkg::sdram_slot;
            else if (vram_pending)
               next_state = ram_pkg::vram_slot;
            else
               next_state = ram_pkg::idle;
         end
         default:
            next_state = ram_pkg::idle;
      endcase
   end

   assign mcr_grant   = (state_q == ram_pkg::mcr_first);
   assign sdram_grant = (state_q == ram_pkg::sdram_slot);
   assign vram_grant  = (state_q == ram_pkg::vram_slot);

   // pins and lane data for the cycle that starts at the next edge.
   always_comb begin
      logic wr;

      wr = 1'b0;
      ctl_d = ctl_q;  // address holds while idle.
      cmd_d = '0;
      cmd_d.capture = next_state;
      case (next_state)
         ram_pkg::mcr_first: begin
            wr = mcr_req.write;
            ctl_d.addr = {ram_pkg::mcr_region, mcr_req.addr, 1'b0};
            cmd_d.lane1 = {12'b0, mcr_req.wdata[51:48]};
            cmd_d.lane2 = mcr_req.wdata[47:32];
         end
         ram_pkg::mcr_second: begin
            wr = mcr_q.write;
            ctl_d.addr = {ram_pkg::mcr_region, mcr_q.addr, 1'b1};
            cmd_d.lane1 = mcr_q.wdata[31:16];
            cmd_d.lane2 = mcr_q.wdata[15:0];
         end
         ram_pkg::sdram_slot: begin
            wr = sdram_req.write;
            ctl_d.addr = {ram_pkg::sdram_region, sdram_req.addr};
            cmd_d.lane1 = sdram_req.wdata[31:16];
            cmd_d.lane2 = sdram_req.wdata[15:0];
         end
         ram_pkg::vram_slot: begin
            wr = vram_req.write;
            ctl_d.addr = {ram_pkg::vram_region, vram_req.addr};
            cmd_d.lane1 = vram_req.wdata[31:16];
            cmd_d.lane2 = vram_req.wdata[15:0];
         end
         default: ;
      endcase
      ctl_d.ce_n = (next_state == ram_pkg::idle);
      ctl_d.ub_n = ctl_d.ce_n;  // no byte writes.
      ctl_d.lb_n = ctl_d.ce_n;
      ctl_d.oe_n = ctl_d.ce_n | wr;
      ctl_d.we_n = ctl_d.ce_n | ~wr;
      cmd_d.drive = ~ctl_d.ce_n & wr;
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state_q  <= ram_pkg::idle;
         ctl_q    <= '{addr: '0, default: 1'b1};
         lane_cmd <= '0;
         wr_tog_q <= 1'b0;
      end else begin
         state_q  <= next_state;
         ctl_q    <= ctl_d;
         lane_cmd <= cmd_d;
         if (!ctl_d.we_n)
            wr_tog_q <= ~wr_tog_q;  // one toggle per write cycle.
      end
   end

   // second mcr cycle works from this copy.
   always_ff @(posedge clk) begin
      if (next_state == ram_pkg::mcr_first)
         mcr_q <= mcr_req;
   end

   // we_n strobes low for the first half of each write cycle.
   always_ff @(negedge clk or posedge reset) begin
      if (reset)
         wr_seen_q <= 1'b0;
      else
         wr_seen_q <= wr_tog_q;
   end

   always_comb begin
      sram_ctl = ctl_q;
      sram_ctl.we_n = ctl_q.we_n | (wr_tog_q == wr_seen_q);
   end

endmodule

// ==== client_port.sv ====
// client_port: single request holding register with busy tracking.
`timescale 1ns/100ps

module client_port #(
   parameter type req_t = logic
) (
   input  logic clk,
   input  logic reset,
   input  logic req_valid,
   input  req_t req,
   input  logic grant,
   input  logic ack,
   output logic busy,
   output logic pending,
   output req_t pending_req
);

   logic busy_q;
   logic accept;

   assign accept = req_valid & ~busy;

   // busy drops in the ack cycle itself.
   assign busy = busy_q & ~ack;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         busy_q  <= 1'b0;
         pending <= 1'b0;
      end else begin
         if (accept) begin
            busy_q  <= 1'b1;
            pending <= 1'b1;
         end else begin
            if (grant)
               pending <= 1'b0;  // sequencer has it now.
            if (ack)
               busy_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept)
         pending_req <= req;
   end

endmodule

// ==== ram_pkg.sv ====
// address, data, request, sequencer state, sram control and lane command types.
package ram_pkg;

   typedef logic [17:0] sram_addr_t;
   typedef logic [15:0] lane_t;
   typedef logic [31:0] word_t;
   typedef logic [51:0] mcr_word_t;
   typedef logic [11:0] mcr_addr_t;
   typedef logic [15:0] sdram_addr_t;
   typedef logic [14:0] vram_addr_t;

   // fixed sram regions per client.
   localparam logic [4:0] mcr_region   = 5'b01000;
   localparam logic [1:0] sdram_region = 2'b00;
   localparam logic [2:0] vram_region  = 3'b110;

   typedef struct packed {
      logic      write;
      mcr_addr_t addr;
      mcr_word_t wdata;
   } mcr_req_t;

   typedef struct packed {
      logic        write;
      sdram_addr_t addr;
      word_t       wdata;
   } sdram_req_t;

   typedef struct packed {
      logic       write;
      vram_addr_t addr;
      word_t      wdata;
   } vram_req_t;

   typedef enum logic [2:0] {
      idle,
      mcr_first,
      mcr_second,
      sdram_slot,
      vram_slot
   } seq_state_t;

   // shared by both chips.
   typedef struct packed {
      sram_addr_t addr;
      logic       oe_n;
      logic       we_n;
      logic       ce_n;
      logic       ub_n;
      logic       lb_n;
   } sram_ctl_t;

   typedef struct packed {
      logic       drive;
      lane_t      lane1;    // upper half, chip 1.
      lane_t      lane2;    // lower half, chip 2.
      seq_state_t capture;  // which client owns this cycle.
   } lane_cmd_t;

endpackage
